// ==== hdl/initiator_rsp_mux.sv ====
// Initiator response mux
// Picks target responses whose ID prefix names this initiator,
// arbitrates round-robin and registers the winner with the prefix
// stripped off

`timescale 1ns/10ps
`default_nettype none

module initiator_rsp_mux #(
  parameter int INIT_IDX = 0
) (
  input  logic                clk,
  input  logic                rst_n,
  rd_rsp_if.monitor           targ_rsp [xbar_pkg::NB_TARG-1:0],
  output xbar_pkg::targ_vec_t take_o,
  rd_rsp_if.source            init_rsp
);

  import xbar_pkg::*;

  targ_vec_t              rsp_valid;
  targ_id_t [NB_TARG-1:0] rsp_id;
  data_t    [NB_TARG-1:0] rsp_data;
  resp_t    [NB_TARG-1:0] rsp_resp;
  targ_vec_t              mine;
  targ_vec_t              arb_req;
  targ_vec_t              take;
  logic                   load_en;
  targ_id_t               sel_id;
  data_t                  sel_data;
  resp_t                  sel_resp;

  logic                   valid_q;
  init_id_t               id_q;
  data_t                  data_q;
  resp_t                  resp_q;

  // Flatten the interface array and route by the ID prefix
  for (genvar k = 0; k < NB_TARG; k++) begin : g_targ
    assign rsp_valid[k] = targ_rsp[k].valid;
    assign rsp_id[k]    = targ_rsp[k].id;
    assign rsp_data[k]  = targ_rsp[k].data;
    assign rsp_resp[k]  = targ_rsp[k].resp;
    assign mine[k]      = rsp_valid[k] &&
                          (rsp_id[k][TARG_ID_W-1 -: INIT_IDX_W] == INIT_IDX_W'(INIT_IDX));
  end

  assign load_en = !valid_q || init_rsp.ready;
  assign arb_req = load_en ? mine : '0;

  rr_arbiter #(
    .N (NB_TARG)
  ) u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (arb_req),
    .advance_i (load_en),
    .grant_o   (take)
  );

  assign take_o = take;

  always_comb begin
    sel_id   = '0;
    sel_data = '0;
    sel_resp = '0;
    for (int k = 0; k < NB_TARG; k++) begin
      if (take[k]) begin
        sel_id   = rsp_id[k];
        sel_data = rsp_data[k];
        sel_resp = rsp_resp[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load_en) begin
      valid_q <= |take;
    end
  end

  // Only the initiator's own ID bits go back upstream
  always_ff @(posedge clk) begin
    if (load_en && (|take)) begin
      id_q   <= sel_id[ID_W-1:0];
      data_q <= sel_data;
      resp_q <= sel_resp;
    end
  end

  assign init_rsp.valid = valid_q;
  assign init_rsp.id    = id_q;
  assign init_rsp.data  = data_q;
  assign init_rsp.resp  = resp_q;

endmodule

`default_nettype wire

// ==== hdl/rd_req_if.sv ====
// Read request channel
// Valid/ready handshake with an ID and an address, sized by ID width

`timescale 1ns/10ps
`default_nettype none

interface rd_req_if #(
  parameter int ID_WIDTH = xbar_pkg::ID_W
) ();

  import xbar_pkg::*;

  logic                valid;
  logic                ready;
  logic [ID_WIDTH-1:0] id;
  addr_t               addr;

  modport source (output valid, output id, output addr, input ready);
  modport sink (input valid, input id, input addr, output ready);

  // Observes a request without taking part in the handshake
  modport monitor (input valid, input id, input addr);

endinterface

`default_nettype wire

// ==== hdl/rd_rsp_if.sv ====
// Read response channel
// Valid/ready handshake carrying ID, read data and response code

`timescale 1ns/10ps
`default_nettype none

interface rd_rsp_if #(
  parameter int ID_WIDTH = xbar_pkg::ID_W
) ();

  import xbar_pkg::*;

  logic                valid;
  logic                ready;
  logic [ID_WIDTH-1:0] id;
  data_t               data;
  resp_t               resp;

  modport source (
    output valid, output id, output data, output resp,
    input  ready
  );

  modport sink (
    input  valid, input id, input data, input resp,
    output ready
  );

  // Used by the response muxes to look at every target
  modport monitor (input valid, input id, input data, input resp);

endinterface

`default_nettype wire

// ==== hdl/read_xbar_top.sv ====
// Read-only crossbar node
// Two initiators reach four targets over a fixed address map.
// Request muxes per target, response muxes per initiator.

`timescale 1ns/10ps
`default_nettype none

module read_xbar_top (
  input  logic                                        clk,
  input  logic                                        rst_n,

  input  xbar_pkg::init_vec_t                         init_req_valid_i,
  input  xbar_pkg::init_id_t [xbar_pkg::NB_INIT-1:0]  init_req_id_i,
  input  xbar_pkg::addr_t    [xbar_pkg::NB_INIT-1:0]  init_req_addr_i,
  output xbar_pkg::init_vec_t                         init_req_ready_o,

  output xbar_pkg::init_vec_t                         init_rsp_valid_o,
  output xbar_pkg::init_id_t [xbar_pkg::NB_INIT-1:0]  init_rsp_id_o,
  output xbar_pkg::data_t    [xbar_pkg::NB_INIT-1:0]  init_rsp_data_o,
  output xbar_pkg::resp_t    [xbar_pkg::NB_INIT-1:0]  init_rsp_resp_o,
  input  xbar_pkg::init_vec_t                         init_rsp_ready_i,

  output xbar_pkg::targ_vec_t                         targ_req_valid_o,
  output xbar_pkg::targ_id_t [xbar_pkg::NB_TARG-1:0]  targ_req_id_o,
  output xbar_pkg::addr_t    [xbar_pkg::NB_TARG-1:0]  targ_req_addr_o,
  input  xbar_pkg::targ_vec_t                         targ_req_ready_i,

  input  xbar_pkg::targ_vec_t                         targ_rsp_valid_i,
  input  xbar_pkg::targ_id_t [xbar_pkg::NB_TARG-1:0]  targ_rsp_id_i,
  input  xbar_pkg::data_t    [xbar_pkg::NB_TARG-1:0]  targ_rsp_data_i,
  input  xbar_pkg::resp_t    [xbar_pkg::NB_TARG-1:0]  targ_rsp_resp_i,
  output xbar_pkg::targ_vec_t                         targ_rsp_ready_o
);

  import xbar_pkg::*;

  rd_req_if #(.ID_WIDTH(ID_W))      init_req [NB_INIT-1:0] ();
  rd_rsp_if #(.ID_WIDTH(ID_W))      init_rsp [NB_INIT-1:0] ();
  rd_req_if #(.ID_WIDTH(TARG_ID_W)) targ_req [NB_TARG-1:0] ();
  rd_rsp_if #(.ID_WIDTH(TARG_ID_W)) targ_rsp [NB_TARG-1:0] ();

  init_vec_t [NB_TARG-1:0] grant;
  targ_vec_t [NB_INIT-1:0] take;
  init_vec_t               init_ready;
  targ_vec_t               targ_ready;

  // Each request addresses one target, so at most one grant per initiator
  always_comb begin
    init_ready = '0;
    for (int k = 0; k < NB_TARG; k++) begin
      init_ready = init_ready | grant[k];
    end
  end

  // Each response carries one prefix, so at most one taker per target
  always_comb begin
    targ_ready = '0;
    for (int i = 0; i < NB_INIT; i++) begin
      targ_ready = targ_ready | take[i];
    end
  end

  for (genvar i = 0; i < NB_INIT; i++) begin : g_init
    assign init_req[i].valid   = init_req_valid_i[i];
    assign init_req[i].id      = init_req_id_i[i];
    assign init_req[i].addr    = init_req_addr_i[i];
    assign init_req[i].ready   = init_ready[i];
    assign init_req_ready_o[i] = init_req[i].ready;

    assign init_rsp_valid_o[i] = init_rsp[i].valid;
    assign init_rsp_id_o[i]    = init_rsp[i].id;
    assign init_rsp_data_o[i]  = init_rsp[i].data;
    assign init_rsp_resp_o[i]  = init_rsp[i].resp;
    assign init_rsp[i].ready   = init_rsp_ready_i[i];

    initiator_rsp_mux #(
      .INIT_IDX (i)
    ) u_rsp_mux (
      .clk      (clk),
      .rst_n    (rst_n),
      .targ_rsp (targ_rsp),
      .take_o   (take[i]),
      .init_rsp (init_rsp[i])
    );
  end

  for (genvar k = 0; k < NB_TARG; k++) begin : g_targ
    assign targ_req_valid_o[k] = targ_req[k].valid;
    assign targ_req_id_o[k]    = targ_req[k].id;
    assign targ_req_addr_o[k]  = targ_req[k].addr;
    assign targ_req[k].ready   = targ_req_ready_i[k];

    assign targ_rsp[k].valid   = targ_rsp_valid_i[k];
    assign targ_rsp[k].id      = targ_rsp_id_i[k];
    assign targ_rsp[k].data    = targ_rsp_data_i[k];
    assign targ_rsp[k].resp    = targ_rsp_resp_i[k];
    assign targ_rsp[k].ready   = targ_ready[k];
    assign targ_rsp_ready_o[k] = targ_rsp[k].ready;

    target_port_mux #(
      .TARGET_IDX (k)
    ) u_req_mux (
      .clk      (clk),
      .rst_n    (rst_n),
      .init_req (init_req),
      .grant_o  (grant[k]),
      .targ_req (targ_req[k])
    );
  end

endmodule

`default_nettype wire

// ==== hdl/rr_arbiter.sv ====
// Round-robin arbiter
// Grants the first requester after the last granted index, wrapping
// around. The pointer moves only when the consumer takes the grant.

`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
  parameter int N = 2
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [N-1:0] req_i,
  input  logic         advance_i,
  output logic [N-1:0] grant_o
);

  localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] win_idx;
  logic             found;

  // Scan starts one past the last winner so it has lowest priority
  always_comb begin
    int cand;
    cand    = 0;
    grant_o = '0;
    win_idx = last_q;
    found   = 1'b0;
    for (int off = 1; off <= N; off++) begin
      cand = (int'(last_q) + off) % N;
      if (!found && req_i[cand]) begin
        found         = 1'b1;
        win_idx       = IDX_W'(cand);
        grant_o[cand] = 1'b1;
      end
    end
  end

  // Pointer starts at the top index, so requester 0 wins first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_q <= IDX_W'(N - 1);
    end else if (advance_i && found) begin
      last_q <= win_idx;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/target_port_mux.sv ====
// Target port request mux
// Matches initiator requests against this target's address window,
// picks one round-robin and registers it with the initiator index
// prepended to its ID

`timescale 1ns/10ps
`default_nettype none

module target_port_mux #(
  parameter int TARGET_IDX = 0
) (
  input  logic                clk,
  input  logic                rst_n,
  rd_req_if.monitor           init_req [xbar_pkg::NB_INIT-1:0],
  output xbar_pkg::init_vec_t grant_o,
  rd_req_if.source            targ_req
);

  import xbar_pkg::*;

  // Lower bound of this target's window
  localparam addr_t WIN_LO = addr_t'(MAP_BASE + addr_t'(TARGET_IDX) * MAP_SPAN);

  init_vec_t              req_valid;
  init_id_t [NB_INIT-1:0] req_id;
  addr_t    [NB_INIT-1:0] req_addr;
  init_vec_t              hit;
  init_vec_t              arb_req;
  init_vec_t              grant;
  logic                   load_en;
  targ_id_t               sel_id;
  addr_t                  sel_addr;

  logic                   valid_q;
  targ_id_t               id_q;
  addr_t                  addr_q;

  // Flatten the interface array and decode the address window
  for (genvar i = 0; i < NB_INIT; i++) begin : g_init
    assign req_valid[i] = init_req[i].valid;
    assign req_id[i]    = init_req[i].id;
    assign req_addr[i]  = init_req[i].addr;
    assign hit[i]       = req_valid[i] && (addr_t'(req_addr[i] - WIN_LO) < MAP_SPAN);
  end

  // Output register takes a new request when empty or draining
  assign load_en = !valid_q || targ_req.ready;
  assign arb_req = load_en ? hit : '0;

  rr_arbiter #(
    .N (NB_INIT)
  ) u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (arb_req),
    .advance_i (load_en),
    .grant_o   (grant)
  );

  assign grant_o = grant;

  // Grant is one-hot, so at most one branch fires
  always_comb begin
    sel_id   = '0;
    sel_addr = '0;
    for (int i = 0; i < NB_INIT; i++) begin
      if (grant[i]) begin
        sel_id   = {INIT_IDX_W'(i), req_id[i]};
        sel_addr = req_addr[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load_en) begin
      valid_q <= |grant;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en && (|grant)) begin
      id_q   <= sel_id;
      addr_q <= sel_addr;
    end
  end

  assign targ_req.valid = valid_q;
  assign targ_req.id    = id_q;
  assign targ_req.addr  = addr_q;

endmodule

`default_nettype wire

// ==== hdl/xbar_pkg.sv ====
// Read crossbar package
// Node sizes, ID widths, the fixed address map and the vector types
// shared by the crossbar blocks

`default_nettype none

package xbar_pkg;

  // Node dimensions
  localparam int NB_INIT = 2;
  localparam int NB_TARG = 4;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Target-side IDs carry the initiator index in their top bits
  localparam int ID_W       = 4;
  localparam int INIT_IDX_W = $clog2(NB_INIT);
  localparam int TARG_ID_W  = ID_W + INIT_IDX_W;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [ID_W-1:0]      init_id_t;
  typedef logic [TARG_ID_W-1:0] targ_id_t;
  typedef logic [1:0]           resp_t;
  typedef logic [NB_INIT-1:0]   init_vec_t;
  typedef logic [NB_TARG-1:0]   targ_vec_t;

  // Target k owns [MAP_BASE + k*MAP_SPAN, MAP_BASE + (k+1)*MAP_SPAN - 1]
  localparam addr_t MAP_BASE = addr_t'(0);
  localparam addr_t MAP_SPAN = addr_t'(32'h0000_1000);

endpackage

`default_nettype wire

// ==== list.f ====
hdl/xbar_pkg.sv
hdl/rd_req_if.sv
hdl/rd_rsp_if.sv
hdl/rr_arbiter.sv
hdl/target_port_mux.sv
hdl/initiator_rsp_mux.sv
hdl/read_xbar_top.sv
tests/read_xbar_sva.sv
tests/tb_read_xbar.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the read crossbar testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_read_xbar \
  -f list.f \
  --Mdir obj_dir -o sim_read_xbar

# Keep running past an assertion so the testbench can report it
./obj_dir/sim_read_xbar +verilator+error+limit+100

// ==== tests/read_xbar_sva.sv ====
// Port-level assertions for the read crossbar
// Reset state of the registered outputs, the target address windows
// and payload stability while an output is back-pressured

`timescale 1ns/10ps
`default_nettype none

module read_xbar_sva (
  input logic                                       clk,
  input logic                                       rst_n,
  input xbar_pkg::init_vec_t                        init_rsp_valid_o,
  input xbar_pkg::init_id_t [xbar_pkg::NB_INIT-1:0] init_rsp_id_o,
  input xbar_pkg::data_t    [xbar_pkg::NB_INIT-1:0] init_rsp_data_o,
  input xbar_pkg::resp_t    [xbar_pkg::NB_INIT-1:0] init_rsp_resp_o,
  input xbar_pkg::init_vec_t                        init_rsp_ready_i,
  input xbar_pkg::targ_vec_t                        targ_req_valid_o,
  input xbar_pkg::targ_id_t [xbar_pkg::NB_TARG-1:0] targ_req_id_o,
  input xbar_pkg::addr_t    [xbar_pkg::NB_TARG-1:0] targ_req_addr_o,
  input xbar_pkg::targ_vec_t                        targ_req_ready_i
);

  import xbar_pkg::*;

  // Number of assertion failures seen so far
  int unsigned fail_cnt = 0;

  // Both output registers come out of reset empty
  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> (targ_req_valid_o == '0) && (init_rsp_valid_o == '0))
    else begin
      fail_cnt++;
      $error("Valid output high in the first cycle after reset");
    end

  for (genvar k = 0; k < NB_TARG; k++) begin : g_targ
    // First and last address of target k
    localparam addr_t WIN_LO = MAP_BASE + addr_t'(k) * MAP_SPAN;
    localparam addr_t WIN_HI = WIN_LO + MAP_SPAN - addr_t'(1);

    a_window: assert property (@(posedge clk) disable iff (!rst_n)
      targ_req_valid_o[k] |->
        (targ_req_addr_o[k] >= WIN_LO) && (targ_req_addr_o[k] <= WIN_HI))
      else begin
        fail_cnt++;
        $error("targ_req_addr_o[%0d] = 0x%08h outside the target window", k,
               targ_req_addr_o[k]);
      end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      targ_req_valid_o[k] && !targ_req_ready_i[k] |=>
        targ_req_valid_o[k] && $stable(targ_req_id_o[k]) && $stable(targ_req_addr_o[k]))
      else begin
        fail_cnt++;
        $error("Target %0d request changed while stalled", k);
      end
  end

  for (genvar i = 0; i < NB_INIT; i++) begin : g_init
    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      init_rsp_valid_o[i] && !init_rsp_ready_i[i] |=>
        init_rsp_valid_o[i] && $stable(init_rsp_id_o[i]) &&
        $stable(init_rsp_data_o[i]) && $stable(init_rsp_resp_o[i]))
      else begin
        fail_cnt++;
        $error("Initiator %0d response changed while stalled", i);
      end
  end

endmodule

bind read_xbar_top read_xbar_sva u_sva (
  .clk              (clk),
  .rst_n            (rst_n),
  .init_rsp_valid_o (init_rsp_valid_o),
  .init_rsp_id_o    (init_rsp_id_o),
  .init_rsp_data_o  (init_rsp_data_o),
  .init_rsp_resp_o  (init_rsp_resp_o),
  .init_rsp_ready_i (init_rsp_ready_i),
  .targ_req_valid_o (targ_req_valid_o),
  .targ_req_id_o    (targ_req_id_o),
  .targ_req_addr_o  (targ_req_addr_o),
  .targ_req_ready_i (targ_req_ready_i)
);

`default_nettype wire

// ==== tests/tb_read_xbar.sv ====
// Testbench for the read crossbar node
// Two random initiators, four target models with random latency,
// response data checked against a table of issued addresses

`timescale 1ns/10ps
`default_nettype none

module tb_read_xbar;

  import xbar_pkg::*;

  localparam int    CLK_PERIOD   = 4;
  localparam int    RESET_CYCLES = 10;
  localparam int    NB_READS     = 200;
  localparam int    NB_IDS       = 1 << ID_W;
  localparam int    WATCHDOG_NS  = (NB_READS * 20 + RESET_CYCLES) * CLK_PERIOD;
  localparam data_t DATA_MASK    = 32'hA5A5_A5A5;

  logic clk;
  logic rst_n;

  init_vec_t              init_req_valid;
  init_id_t [NB_INIT-1:0] init_req_id;
  addr_t    [NB_INIT-1:0] init_req_addr;
  init_vec_t              init_req_ready;
  init_vec_t              init_rsp_valid;
  init_id_t [NB_INIT-1:0] init_rsp_id;
  data_t    [NB_INIT-1:0] init_rsp_data;
  resp_t    [NB_INIT-1:0] init_rsp_resp;
  init_vec_t              init_rsp_ready;
  targ_vec_t              targ_req_valid;
  targ_id_t [NB_TARG-1:0] targ_req_id;
  addr_t    [NB_TARG-1:0] targ_req_addr;
  targ_vec_t              targ_req_ready;
  targ_vec_t              targ_rsp_valid;
  targ_id_t [NB_TARG-1:0] targ_rsp_id;
  data_t    [NB_TARG-1:0] targ_rsp_data;
  resp_t    [NB_TARG-1:0] targ_rsp_resp;
  targ_vec_t              targ_rsp_ready;

  // Reads accepted, responses taken and last address per initiator and ID
  int    issued_cnt [NB_INIT][NB_IDS];
  int    done_cnt   [NB_INIT][NB_IDS];
  addr_t addr_tab   [NB_INIT][NB_IDS];
  int    rsp_total  [NB_INIT];
  // Grants lost to the other initiator while waiting on a target
  int    lost_turns [NB_TARG][NB_INIT];

  read_xbar_top UUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .init_req_valid_i (init_req_valid),
    .init_req_id_i    (init_req_id),
    .init_req_addr_i  (init_req_addr),
    .init_req_ready_o (init_req_ready),
    .init_rsp_valid_o (init_rsp_valid),
    .init_rsp_id_o    (init_rsp_id),
    .init_rsp_data_o  (init_rsp_data),
    .init_rsp_resp_o  (init_rsp_resp),
    .init_rsp_ready_i (init_rsp_ready),
    .targ_req_valid_o (targ_req_valid),
    .targ_req_id_o    (targ_req_id),
    .targ_req_addr_o  (targ_req_addr),
    .targ_req_ready_i (targ_req_ready),
    .targ_rsp_valid_i (targ_rsp_valid),
    .targ_rsp_id_i    (targ_rsp_id),
    .targ_rsp_data_i  (targ_rsp_data),
    .targ_rsp_resp_i  (targ_rsp_resp),
    .targ_rsp_ready_o (targ_rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  function automatic int target_of(input addr_t a);
    return int'((a - MAP_BASE) / MAP_SPAN);
  endfunction

  function automatic logic is_outstanding(input int init, input int id);
    return issued_cnt[init][id] != done_cnt[init][id];
  endfunction

  task automatic drive_initiator(input int i);
    int    start;
    int    slot;
    int    targ;
    int    gap;
    addr_t addr;
    for (int n = 0; n < NB_READS; n++) begin
      // Pick a free ID, starting the scan at a random point
      slot = -1;
      while (slot < 0) begin
        start = int'($urandom_range(0, NB_IDS - 1));
        for (int s = 0; s < NB_IDS; s++) begin
          if (slot < 0 && !is_outstanding(i, (start + s) % NB_IDS)) begin
            slot = (start + s) % NB_IDS;
          end
        end
        if (slot < 0) begin
          // No request goes out while every ID is in use
          init_req_valid[i] = 1'b0;
          @(posedge clk);
          #1;
        end
      end
      targ = int'($urandom_range(0, NB_TARG - 1));
      addr = MAP_BASE + addr_t'(targ) * MAP_SPAN +
             addr_t'($urandom_range(0, int'(MAP_SPAN) - 1));
      init_req_valid[i] = 1'b1;
      init_req_id[i]    = init_id_t'(slot);
      init_req_addr[i]  = addr;
      do begin
        @(negedge clk);
      end while (!init_req_ready[i]);
      addr_tab[i][slot]   = addr;
      issued_cnt[i][slot] = issued_cnt[i][slot] + 1;
      @(posedge clk);
      #1;
      gap = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0;
      if (gap > 0) begin
        init_req_valid[i] = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
    end
    init_req_valid[i] = 1'b0;
  endtask

  task automatic check_initiator(input int i);
    init_id_t rid;
    data_t    exp_data;
    forever begin
      @(negedge clk);
      if (init_rsp_valid[i] && init_rsp_ready[i]) begin
        rid      = init_rsp_id[i];
        exp_data = addr_tab[i][rid] ^ DATA_MASK;
        assert (is_outstanding(i, int'(rid))) else report_failure($sformatf(
          "** Error: init_rsp_id_o[%0d] = 0x%0h has no outstanding read", i, rid));
        assert (init_rsp_data[i] == exp_data) else report_failure($sformatf(
          "** Error: init_rsp_data_o[%0d] = 0x%08h, expected 0x%08h",
          i, init_rsp_data[i], exp_data));
        assert (init_rsp_resp[i] == 2'b00) else report_failure($sformatf(
          "** Error: init_rsp_resp_o[%0d] = 0x%0h, expected 0x0", i, init_rsp_resp[i]));
        done_cnt[i][rid] = done_cnt[i][rid] + 1;
        rsp_total[i]     = rsp_total[i] + 1;
      end
      @(posedge clk);
      #1;
      init_rsp_ready[i] = ($urandom_range(0, 3) != 0);
    end
  endtask

  // Target model that queues accepted reads and answers after 0 to 4 cycles
  task automatic run_target(input int k);
    targ_id_t q_id [$];
    addr_t    q_addr [$];
    int       q_due [$];
    int       cyc;
    logic     req_take;
    logic     rsp_done;
    cyc = 0;
    forever begin
      @(negedge clk);
      req_take = targ_req_valid[k] && targ_req_ready[k];
      rsp_done = targ_rsp_valid[k] && targ_rsp_ready[k];
      if (req_take) begin
        q_id.push_back(targ_req_id[k]);
        q_addr.push_back(targ_req_addr[k]);
        q_due.push_back(cyc + int'($urandom_range(0, 4)));
      end
      @(posedge clk);
      #1;
      cyc++;
      if (rsp_done) begin
        targ_rsp_valid[k] = 1'b0;
      end
      if (!targ_rsp_valid[k] && q_due.size() > 0 && q_due[0] <= cyc) begin
        targ_rsp_valid[k] = 1'b1;
        targ_rsp_id[k]    = q_id.pop_front();
        targ_rsp_data[k]  = q_addr.pop_front() ^ DATA_MASK;
        targ_rsp_resp[k]  = 2'b00;
        void'(q_due.pop_front());
      end
      targ_req_ready[k] = ($urandom_range(0, 3) != 0);
    end
  endtask

  // Target request ID prefix and round-robin fairness between the initiators
  task automatic watch_requests();
    int p;
    int lid;
    int other;
    forever begin
      @(negedge clk);
      for (int k = 0; k < NB_TARG; k++) begin
        if (targ_req_valid[k]) begin
          p   = int'(targ_req_id[k][TARG_ID_W-1 -: INIT_IDX_W]);
          lid = int'(targ_req_id[k][ID_W-1:0]);
          assert (is_outstanding(p, lid)) else report_failure($sformatf(
            "** Error: targ_req_id_o[%0d] = 0x%0h names no outstanding read", k, targ_req_id[k]));
        end
        for (int i = 0; i < NB_INIT; i++) begin
          // Two initiators, so the rival is the other index
          other = NB_INIT - 1 - i;
          if (!init_req_valid[i] || target_of(init_req_addr[i]) != k || init_req_ready[i]) begin
            lost_turns[k][i] = 0;
          end else if (init_req_valid[other] && init_req_ready[other] &&
                       target_of(init_req_addr[other]) == k) begin
            lost_turns[k][i] = lost_turns[k][i] + 1;
            assert (lost_turns[k][i] < 2) else report_failure($sformatf(
              "Initiator %0d was passed over twice for target %0d", i, k));
          end
        end
      end
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_failure($sformatf("Timeout: reads did not complete within %0d ns", WATCHDOG_NS));
  end

  initial begin
    wait (UUT.u_sva.fail_cnt != 0);
    report_failure("A bound assertion on the DUT ports failed");
  end

  initial begin
    void'($urandom(86));
    rst_n          = 1'b0;
    init_req_valid = '0;
    init_req_id    = '0;
    init_req_addr  = '0;
    init_rsp_ready = '0;
    targ_req_ready = '0;
    targ_rsp_valid = '0;
    targ_rsp_id    = '0;
    targ_rsp_data  = '0;
    targ_rsp_resp  = '0;
    for (int i = 0; i < NB_INIT; i++) begin
      rsp_total[i] = 0;
      for (int d = 0; d < NB_IDS; d++) begin
        issued_cnt[i][d] = 0;
        done_cnt[i][d]   = 0;
        addr_tab[i][d]   = '0;
      end
      for (int k = 0; k < NB_TARG; k++) begin
        lost_turns[k][i] = 0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fork
      drive_initiator(0);
      drive_initiator(1);
      check_initiator(0);
      check_initiator(1);
      run_target(0);
      run_target(1);
      run_target(2);
      run_target(3);
      watch_requests();
    join_none
    wait (rsp_total[0] == NB_READS && rsp_total[1] == NB_READS);
    repeat (4) @(posedge clk);
    if (UUT.u_sva.fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      report_failure("A bound assertion on the DUT ports failed");
    end
  end

endmodule

`default_nettype wire
